// File: flist.f
+incdir+sim
hw/snakePkg.sv
hw/snakeBody.sv
hw/tileRasterizer.sv
hw/gameSequencer.sv
hw/snakeGameTop.sv
sim/snakeGameTb.sv

// File: hw/gameSequencer.sv
// ============================================================================
// game sequencer
// FSM for apple draw, snake draw, erase, move, collision check, game over
// picks the tile and colour for each rasterizer pass
// ============================================================================
`timescale 1ns/10ps

module gameSequencer import snakePkg::*; (
    input  logic      Clock,
    input  logic      reset,
    input  logic      start,
    input  logic      stepTick,
    input  colour_t   snakeColour,
    input  tile_t     segment,
    input  logic      hit,
    input  logic      tileDone,
    output segIndex_t segmentIndex,
    output logic      move,
    output logic      tileStart,
    output tile_t     drawTile,
    output colour_t   drawColour,
    output logic      gameOver
);

    typedef enum logic [2:0] {
        stIdle,
        stApple,
        stDraw,
        stWaitStep,
        stErase,
        stMove,
        stCheck,
        stOver
    } seqState_t;

    seqState_t state;
    segIndex_t segCount;
    logic      lastSegment;

    assign lastSegment  = (segCount == segIndex_t'(SnakeLength - 1));
    assign segmentIndex = segCount;

    // move is a single cycle, the next state samples hit
    assign move     = (state == stMove);
    assign gameOver = (state == stOver);

    // tile source and colour by phase
    always_comb begin
        drawTile   = segment;
        drawColour = snakeColour;
        if (state == stApple) begin
            drawTile   = AppleTile;
            drawColour = AppleColour;
        end else if (state == stErase) begin
            drawColour = EraseColour;
        end
    end

    // tileStart is raised the cycle after a phase begins or a tile ends,
    // so the rasterizer has always gone idle by then
    always_ff @(posedge Clock) begin
        if (reset) begin
            state     <= stIdle;
            segCount  <= '0;
            tileStart <= 1'b0;
        end else begin
            tileStart <= 1'b0;
            case (state)
                stIdle: begin
                    if (start) begin
                        state     <= stApple;
                        tileStart <= 1'b1;
                    end
                end
                // apple once, then the whole body
                stApple: begin
                    if (tileDone) begin
                        state     <= stDraw;
                        segCount  <= '0;
                        tileStart <= 1'b1;
                    end
                end
                stDraw: begin
                    if (tileDone) begin
                        if (lastSegment) begin
                            state <= stWaitStep;
                        end else begin
                            segCount  <= segCount + 1'b1;
                            tileStart <= 1'b1;
                        end
                    end
                end
                // ticks outside this state are dropped
                stWaitStep: begin
                    if (stepTick) begin
                        state     <= stErase;
                        segCount  <= '0;
                        tileStart <= 1'b1;
                    end
                end
                // erase uses the old positions
                stErase: begin
                    if (tileDone) begin
                        if (lastSegment) begin
                            state <= stMove;
                        end else begin
                            segCount  <= segCount + 1'b1;
                            tileStart <= 1'b1;
                        end
                    end
                end
                stMove: begin
                    state <= stCheck;
                end
                // verdict on the moved body
                stCheck: begin
                    if (hit) begin
                        state <= stOver;
                    end else begin
                        state     <= stDraw;
                        segCount  <= '0;
                        tileStart <= 1'b1;
                    end
                end
                // only reset leaves
                stOver: begin
                    state <= stOver;
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    // a finished tile always belongs to a drawing phase
    doneWhileDrawing: assert property (@(posedge Clock) disable iff (reset)
        tileDone |-> (state == stApple || state == stDraw || state == stErase));

endmodule

// File: hw/snakeBody.sv
// ============================================================================
// snake body store
// segment shift register, direction latch, wrapped head update
// segment readout by index and self-collision check
// ============================================================================
`timescale 1ns/10ps

module snakeBody import snakePkg::*; (
    input  logic      Clock,
    input  logic      reset,
    input  keys_t     keys,
    input  logic      move,
    input  segIndex_t segmentIndex,
    output tile_t     segment,
    output logic      hit
);

    tile_t      segments [SnakeLength];
    direction_t direction;
    tile_t      newHead;

    // latch the strongest pressed key every cycle
    // priority right, down, up, left
    always_ff @(posedge Clock) begin
        if (reset) begin
            direction <= dirUp;
        end else if (keys[0]) begin
            direction <= dirRight;
        end else if (keys[1]) begin
            direction <= dirDown;
        end else if (keys[2]) begin
            direction <= dirUp;
        end else if (keys[3]) begin
            direction <= dirLeft;
        end
    end

    // next head tile, wraps at grid edges
    always_comb begin
        newHead = segments[0];
        case (direction)
            dirUp: begin
                newHead.y = (segments[0].y == 0) ? tileY_t'(GridHeight - 1)
                                                 : segments[0].y - 1'b1;
            end
            dirDown: begin
                newHead.y = (segments[0].y == tileY_t'(GridHeight - 1)) ? '0
                                                                        : segments[0].y + 1'b1;
            end
            dirLeft: begin
                newHead.x = (segments[0].x == 0) ? tileX_t'(GridWidth - 1)
                                                 : segments[0].x - 1'b1;
            end
            default: begin
                newHead.x = (segments[0].x == tileX_t'(GridWidth - 1)) ? '0
                                                                       : segments[0].x + 1'b1;
            end
        endcase
    end

    // body starts as a vertical line below the head
    // on move every segment takes the tile of the one ahead
    always_ff @(posedge Clock) begin
        if (reset) begin
            for (int i = 0; i < SnakeLength; i++) begin
                segments[i].x <= StartHead.x;
                segments[i].y <= tileY_t'(StartHead.y + i);
            end
        end else if (move) begin
            for (int i = SnakeLength - 1; i > 0; i--) begin
                segments[i] <= segments[i - 1];
            end
            segments[0] <= newHead;
        end
    end

    // readout for the sequencer, out of range falls back to head
    always_comb begin
        segment = segments[0];
        for (int i = 0; i < SnakeLength; i++) begin
            if (segmentIndex == segIndex_t'(i)) begin
                segment = segments[i];
            end
        end
    end

    // head on top of any other segment
    always_comb begin
        hit = 1'b0;
        for (int i = 1; i < SnakeLength; i++) begin
            if (segments[i] == segments[0]) begin
                hit = 1'b1;
            end
        end
    end

    // game must stop before a colliding snake moves again
    noMoveOnHit: assert property (@(posedge Clock) disable iff (reset)
        move |-> !hit);

endmodule

// File: hw/snakeGameTop.sv
// ============================================================================
// snake game top level
// body store and rasterizer side by side, joined by the sequencer
// pixels leave as a valid/ready stream
// ============================================================================
`timescale 1ns/10ps

module snakeGameTop import snakePkg::*; (
    input  logic    Clock,
    input  logic    reset,
    input  logic    start,
    input  logic    stepTick,
    input  keys_t   keys,
    input  colour_t snakeColour,
    input  logic    pixelReady,
    output pixel_t  pixel,
    output logic    pixelValid,
    output logic    gameOver
);

    // sequencer and body
    segIndex_t segmentIndex;
    tile_t     segment;
    logic      move;
    logic      hit;

    // sequencer and rasterizer
    logic    tileStart;
    logic    tileDone;
    tile_t   drawTile;
    colour_t drawColour;

    snakeBody i_snakeBody (
        .Clock        (Clock),
        .reset        (reset),
        .keys         (keys),
        .move         (move),
        .segmentIndex (segmentIndex),
        .segment      (segment),
        .hit          (hit)
    );

    tileRasterizer i_tileRasterizer (
        .Clock      (Clock),
        .reset      (reset),
        .tileStart  (tileStart),
        .drawTile   (drawTile),
        .drawColour (drawColour),
        .pixel      (pixel),
        .pixelValid (pixelValid),
        .pixelReady (pixelReady),
        .tileDone   (tileDone)
    );

    gameSequencer i_gameSequencer (
        .Clock        (Clock),
        .reset        (reset),
        .start        (start),
        .stepTick     (stepTick),
        .snakeColour  (snakeColour),
        .segment      (segment),
        .hit          (hit),
        .tileDone     (tileDone),
        .segmentIndex (segmentIndex),
        .move         (move),
        .tileStart    (tileStart),
        .drawTile     (drawTile),
        .drawColour   (drawColour),
        .gameOver     (gameOver)
    );

endmodule

// File: hw/snakePkg.sv
// ============================================================================
// shared definitions for the snake game
// grid and tile constants, start positions and colours
// coordinate, colour and index types, tile and pixel structs
// direction enum used by the body store
// ============================================================================
package snakePkg;

    // screen is covered by a 16 x 12 grid of 10 x 10 pixel tiles
    localparam int TileSize   = 10;
    localparam int GridWidth  = 16;
    localparam int GridHeight = 12;
    localparam int TilePixels = TileSize * TileSize;

    // snake has a fixed length, head is segment 0
    localparam int SnakeLength = 6;

    // tile coordinates
    typedef logic [3:0] tileX_t;
    typedef logic [3:0] tileY_t;

    // screen coordinates, 160 x 120
    typedef logic [7:0] pixelX_t;
    typedef logic [6:0] pixelY_t;

    // one bit each of red, green, blue
    typedef logic [2:0] colour_t;

    // segment index, 0 is the head
    typedef logic [2:0] segIndex_t;

    // key vector, 1 while pressed
    // bit 0 right, bit 1 down, bit 2 up, bit 3 left
    typedef logic [3:0] keys_t;

    typedef struct packed {
        tileX_t x;
        tileY_t y;
    } tile_t;

    // one pixel of the outgoing stream
    typedef struct packed {
        pixelX_t x;
        pixelY_t y;
        colour_t colour;
    } pixel_t;

    typedef enum logic [1:0] {
        dirUp,
        dirDown,
        dirLeft,
        dirRight
    } direction_t;

    // apple sits on a fixed tile
    localparam tile_t AppleTile = '{x: 4'd3, y: 4'd3};

    // head start tile, body trails downward from here
    localparam tile_t StartHead = '{x: 4'd8, y: 4'd6};

    // red apple
    localparam colour_t AppleColour = 3'b100;

    // background is black
    localparam colour_t EraseColour = 3'b000;

endpackage

// File: hw/tileRasterizer.sv
// ============================================================================
// tile rasterizer
// walks the 100 pixels of one tile, row by row, left to right
// streams them out under a valid/ready handshake
// ============================================================================
`timescale 1ns/10ps

module tileRasterizer import snakePkg::*; (
    input  logic    Clock,
    input  logic    reset,
    input  logic    tileStart,
    input  tile_t   drawTile,
    input  colour_t drawColour,
    output pixel_t  pixel,
    output logic    pixelValid,
    input  logic    pixelReady,
    output logic    tileDone
);

    tile_t   tileReg;
    colour_t colourReg;

    // offsets inside the tile
    logic [$clog2(TileSize)-1:0]   rowOffset;
    logic [$clog2(TileSize)-1:0]   colOffset;
    logic [$clog2(TilePixels)-1:0] pixelCount;

    logic accept;
    logic lastPixel;

    assign accept    = pixelValid && pixelReady;
    assign lastPixel = (pixelCount == TilePixels - 1);

    // done as the final pixel is taken
    assign tileDone = accept && lastPixel;

    // tile and colour held for the whole walk
    always_ff @(posedge Clock) begin
        if (tileStart) begin
            tileReg   <= drawTile;
            colourReg <= drawColour;
        end
    end

    // counters only advance on an accepted pixel
    always_ff @(posedge Clock) begin
        if (reset) begin
            pixelValid <= 1'b0;
            rowOffset  <= '0;
            colOffset  <= '0;
            pixelCount <= '0;
        end else if (tileStart) begin
            pixelValid <= 1'b1;
            rowOffset  <= '0;
            colOffset  <= '0;
            pixelCount <= '0;
        end else if (accept) begin
            pixelCount <= pixelCount + 1'b1;
            if (lastPixel) begin
                pixelValid <= 1'b0;
            end
            // end of a row, back to the left edge
            if (colOffset == TileSize - 1) begin
                colOffset <= '0;
                rowOffset <= rowOffset + 1'b1;
            end else begin
                colOffset <= colOffset + 1'b1;
            end
        end
    end

    // screen position is tile origin plus offset
    always_comb begin
        pixel.x      = pixelX_t'(tileReg.x * TileSize + colOffset);
        pixel.y      = pixelY_t'(tileReg.y * TileSize + rowOffset);
        pixel.colour = colourReg;
    end

    // stalled pixel is held until taken
    holdOnStall: assert property (@(posedge Clock) disable iff (reset)
        pixelValid && !pixelReady |=> pixelValid && $stable(pixel));

endmodule

// File: sim/snakeModel.svh
// ============================================================================
// reference model for the snake game testbench
// snake positions, key priority, wrapped moves, collision rule
// expected pixel stream queue and the Galois LFSR bit source
// ============================================================================
`ifndef SNAKE_MODEL_SVH
`define SNAKE_MODEL_SVH

// random source, seeded once
logic [31:0] lfsrState = 32'h9810;

// model snake, head at index 0
tile_t modelSegs [SnakeLength];
int    modelDx;
int    modelDy;

// pixels still owed by the DUT, in order
pixel_t expQ [$];

// one Galois step per bit taken
function automatic logic nextBit();
    logic outBit;
    outBit = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (outBit) begin
        lfsrState = lfsrState ^ 32'h8020_0003;
    end
    return outBit;
endfunction

// vertical line below the head, heading up
function automatic void resetModel();
    for (int i = 0; i < SnakeLength; i++) begin
        modelSegs[i].x = StartHead.x;
        modelSegs[i].y = tileY_t'(StartHead.y + i);
    end
    modelDx = 0;
    modelDy = -1;
endfunction

// priority right, down, up, left, idle keeps heading
function automatic void latchKeys(keys_t pressed);
    if (pressed[0]) begin
        modelDx = 1;
        modelDy = 0;
    end else if (pressed[1]) begin
        modelDx = 0;
        modelDy = 1;
    end else if (pressed[2]) begin
        modelDx = 0;
        modelDy = -1;
    end else if (pressed[3]) begin
        modelDx = -1;
        modelDy = 0;
    end
endfunction

// body follows the head, head wraps modulo the grid
function automatic void moveSnake();
    int headX;
    int headY;
    headX = (int'(modelSegs[0].x) + modelDx + GridWidth) % GridWidth;
    headY = (int'(modelSegs[0].y) + modelDy + GridHeight) % GridHeight;
    for (int i = SnakeLength - 1; i > 0; i--) begin
        modelSegs[i] = modelSegs[i - 1];
    end
    modelSegs[0].x = tileX_t'(headX);
    modelSegs[0].y = tileY_t'(headY);
endfunction

function automatic logic snakeHit();
    logic found;
    found = 1'b0;
    for (int i = 1; i < SnakeLength; i++) begin
        if (modelSegs[i] == modelSegs[0]) begin
            found = 1'b1;
        end
    end
    return found;
endfunction

// rows top to bottom, columns left to right
function automatic void queueTile(tile_t where, colour_t colour);
    pixel_t p;
    for (int row = 0; row < TileSize; row++) begin
        for (int col = 0; col < TileSize; col++) begin
            p.x      = pixelX_t'(where.x * TileSize + col);
            p.y      = pixelY_t'(where.y * TileSize + row);
            p.colour = colour;
            expQ.push_back(p);
        end
    end
endfunction

// all segments, head first
function automatic void queueSnake(colour_t colour);
    for (int i = 0; i < SnakeLength; i++) begin
        queueTile(modelSegs[i], colour);
    end
endfunction

`endif

// File: sim/snakeGameTb.sv
// ============================================================================
// testbench for the snake game top level
// clock, reset, random ready and keys, stray step ticks
// pixel stream checks against the model, game over checks, timeout
// ============================================================================
`timescale 1ns/10ps

module snakeGameTb import snakePkg::*; ();

    localparam int NumSteps   = 40;
    localparam int CycleLimit = NumSteps * 1300 * 4 + 2000;

    logic    Clock;
    logic    reset;
    logic    start;
    logic    stepTick;
    keys_t   keys;
    colour_t snakeColour;
    logic    pixelReady;
    pixel_t  pixel;
    logic    pixelValid;
    logic    gameOver;

    int pixelErrors  = 0;
    int flagErrors   = 0;
    int streamErrors = 0;
    int pixelsSeen   = 0;
    int cycleCount   = 0;
    int steps        = 0;

    pixel_t expected;

    `include "snakeModel.svh"

    snakeGameTop i_snakeGameTop (
        .Clock       (Clock),
        .reset       (reset),
        .start       (start),
        .stepTick    (stepTick),
        .keys        (keys),
        .snakeColour (snakeColour),
        .pixelReady  (pixelReady),
        .pixel       (pixel),
        .pixelValid  (pixelValid),
        .gameOver    (gameOver)
    );

    initial begin
        Clock = 1'b0;
        forever #2 Clock = ~Clock;
    end

    // first pixel of a tile, origin and colour
    task automatic compareTile(pixel_t got, pixel_t exp);
        if (got !== exp) begin
            pixelErrors++;
            $display("[FAIL] %0t: tile starts at (%0d,%0d) colour %b, %s (%0d,%0d) colour %b",
                $time, got.x, got.y, got.colour, "expected tile origin",
                exp.x, exp.y, exp.colour);
        end
    endtask

    // remaining pixels inside a tile
    task automatic comparePixel(pixel_t got, pixel_t exp);
        if (got !== exp) begin
            pixelErrors++;
            $display("[FAIL] %0t: pixel (%0d,%0d) colour %b, expected (%0d,%0d) colour %b",
                $time, got.x, got.y, got.colour, exp.x, exp.y, exp.colour);
        end
    endtask

    task automatic compareFlag(string what, logic got, logic exp);
        if (got !== exp) begin
            flagErrors++;
            $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // sample between edges, a transfer completes on the next rising edge
    always @(negedge Clock) begin
        if (!reset && pixelValid && pixelReady) begin
            pixelsSeen++;
            if (expQ.size() == 0) begin
                streamErrors++;
                $display("Unexpected pixel at (%0d,%0d) at %0t while none was due",
                    pixel.x, pixel.y, $time);
            end else begin
                expected = expQ.pop_front();
                if (expected.x % TileSize == 0 && expected.y % TileSize == 0) begin
                    compareTile(pixel, expected);
                end else begin
                    comparePixel(pixel, expected);
                end
            end
        end
    end

    always @(posedge Clock) begin
        cycleCount++;
        if (cycleCount > CycleLimit) begin
            $display("Timeout after %0d cycles with %0d pixels still due",
                cycleCount, expQ.size());
            $display("Test failed");
            $finish;
        end
    end

    // one cycle, random ready, stray ticks only while pixels are due
    task automatic stepCycle();
        @(posedge Clock);
        #1;
        pixelReady = nextBit();
        if (expQ.size() > 0) begin
            stepTick = nextBit() & nextBit();
        end else begin
            stepTick = 1'b0;
        end
    endtask

    task automatic drain();
        while (expQ.size() > 0) begin
            stepCycle();
        end
    endtask

    // idle outputs, then apple and snake at the start tiles
    task automatic startGame();
        stepCycle();
        compareFlag("pixelValid after reset", pixelValid, 1'b0);
        compareFlag("gameOver after reset", gameOver, 1'b0);
        queueTile(AppleTile, AppleColour);
        queueSnake(snakeColour);
        start = 1'b1;
        stepCycle();
        start = 1'b0;
        drain();
    endtask

    task automatic restartGame();
        reset = 1'b1;
        keys  = '0;
        repeat (5) stepCycle();
        reset = 1'b0;
        resetModel();
        startGame();
    endtask

    // erase, move, then redraw or game over
    task automatic runStep();
        logic      anyKey;
        logic [1:0] keyIdx;
        logic      collided;
        anyKey = nextBit();
        keyIdx = {nextBit(), nextBit()};
        keys   = anyKey ? keys_t'(1 << keyIdx) : '0;
        latchKeys(keys);
        queueSnake(EraseColour);
        moveSnake();
        collided = snakeHit();
        if (!collided) begin
            queueSnake(snakeColour);
        end
        stepTick = 1'b1;
        stepCycle();
        drain();
        if (collided) begin
            for (int i = 0; i < 20 && !gameOver; i++) begin
                stepCycle();
            end
            compareFlag("gameOver after collision", gameOver, 1'b1);
            // nothing more may leave the DUT
            repeat (20) stepCycle();
            compareFlag("gameOver held", gameOver, 1'b1);
            restartGame();
        end else begin
            compareFlag("gameOver while playing", gameOver, 1'b0);
        end
    endtask

    initial begin
        reset       = 1'b1;
        start       = 1'b0;
        stepTick    = 1'b0;
        keys        = '0;
        snakeColour = 3'b010;
        pixelReady  = 1'b0;
        resetModel();
        repeat (5) @(posedge Clock);
        #1;
        reset = 1'b0;
        startGame();
        while (steps < NumSteps) begin
            runStep();
            steps++;
        end
        $display("steps %0d, pixels %0d, pixel errors %0d, flag errors %0d, stream errors %0d",
            steps, pixelsSeen, pixelErrors, flagErrors, streamErrors);
        if (pixelErrors + flagErrors + streamErrors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
